// ==== src/rdp_pkg.sv ====
/*
 * Shared constants, state and register enums, and the packed structs that
 * carry sequencer commands, FIFO controls and status through the read path
 */
package rdp_pkg;

    // Half-rate operation gives two controller beats per AFI clock
    localparam int AFI_RATE_RATIO = 2;
    // Each AFI beat carries two DDR beats, so one AFI word spans four
    localparam int BEATS_PER_WORD = 2 * AFI_RATE_RATIO;

    localparam int NUM_OF_DQDQS     = 2;
    localparam int DQDQS_DATA_WIDTH = 8;
    localparam int AFI_DATA_WIDTH   = 4 * NUM_OF_DQDQS * DQDQS_DATA_WIDTH;

    // Depth of the read-enable shift register inside the predictor
    localparam int MAX_READ_LATENCY = 16;

    localparam int VFIFO_PTR_WIDTH = 3;
    localparam int TIMER_WIDTH     = 4;
    localparam int WB_DATA_WIDTH   = 32;

    typedef enum logic [1:0] {
        ST_FLUSH = 2'd0,
        ST_FILL  = 2'd1,
        ST_RUN   = 2'd2
    } startup_state_e;

    // Register map, selected by the single Wishbone address bit
    typedef enum logic {
        REG_CTRL   = 1'b0,
        REG_STATUS = 1'b1
    } csr_reg_e;

    // Bit 0 is the FIFO reset and bit 1 the pointer increment, as in REG_CTRL
    typedef struct packed {
        logic incr_vfifo;
        logic fifo_reset;
    } seq_cmd_t;

    typedef struct packed {
        logic flush;
        logic rd_en;
        logic wr_en;
    } fifo_ctrl_t;

    // Pointer sits in bits 2:0, state in 4:3 and the sticky error in bit 5
    typedef struct packed {
        logic [WB_DATA_WIDTH-VFIFO_PTR_WIDTH-4:0] pad;
        logic                                      fifo_error;
        startup_state_e                            state;
        logic [VFIFO_PTR_WIDTH-1:0]                vfifo_pointer;
    } status_t;

endpackage

// ==== src/seq_csr_wb.sv ====
/*
 * Wishbone classic register slave standing in for the calibration sequencer
 * Turns control writes into one-cycle command pulses and returns status
 */
`timescale 1ns/1ps

module seq_csr_wb (
    input  logic                                pll_afi_clk,
    input  logic                                reset_n_afi_clk,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic                                wb_adr,
    input  logic [rdp_pkg::WB_DATA_WIDTH-1:0]   wb_dat_i,
    output logic [rdp_pkg::WB_DATA_WIDTH-1:0]   wb_dat_o,
    output logic                                wb_ack,
    output rdp_pkg::seq_cmd_t                   seq_cmd,
    input  logic [rdp_pkg::VFIFO_PTR_WIDTH-1:0] vfifo_pointer,
    input  rdp_pkg::startup_state_e             state,
    input  logic                                fifo_error
);
    import rdp_pkg::*;

    csr_reg_e reg_sel;
    logic     bus_req;
    logic     error_sticky;
    status_t  status;

    assign reg_sel = csr_reg_e'(wb_adr);

    // A request counts once, in the cycle before it is acknowledged
    assign bus_req = wb_cyc && wb_stb && !wb_ack;

    // Ack follows the request by one cycle and the command pulse goes out with it
    always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
    begin
        if (!reset_n_afi_clk)
        begin
            wb_ack  <= 1'b0;
            seq_cmd <= '0;
        end
        else
        begin
            wb_ack <= bus_req;
            // Command bits self-clear after a single cycle
            if (bus_req && wb_we && reg_sel == REG_CTRL)
                seq_cmd <= seq_cmd_t'(wb_dat_i[$bits(seq_cmd_t)-1:0]);
            else
                seq_cmd <= '0;
        end
    end

    // Any FIFO fault stays visible to the sequencer until the next reset
    always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
    begin
        if (!reset_n_afi_clk)
            error_sticky <= 1'b0;
        else if (fifo_error)
            error_sticky <= 1'b1;
    end

    always_comb
    begin
        status               = '0;
        status.vfifo_pointer = vfifo_pointer;
        status.state         = state;
        status.fifo_error    = error_sticky;
    end

    // Read data is only valid alongside ack, and REG_CTRL reads back as zero
    assign wb_dat_o = (wb_ack && !wb_we && reg_sel == REG_STATUS) ? status : '0;

    // Ack only ever lands inside a cycle that the master still holds open
    ack_needs_request: assert property (
        @(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
        wb_ack |-> (wb_cyc && wb_stb)
    );

endmodule

// ==== src/startup_timer.sv ====
/*
 * Saturating startup counter that the startup FSM restarts and reads
 */
`timescale 1ns/1ps

module startup_timer (
    input  logic                            pll_afi_clk,
    input  logic                            reset_n_afi_clk,
    input  logic                            restart,
    output logic [rdp_pkg::TIMER_WIDTH-1:0] count
);

    // Counts every cycle and holds at all ones so the thresholds stay passed
    always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
    begin
        if (!reset_n_afi_clk)
            count <= '0;
        else if (restart)
            count <= '0;
        else if (count != '1)
            count <= count + 1'b1;
    end

endmodule

// ==== src/read_startup_ctrl.sv ====
/*
 * Startup FSM for the read-data FIFO
 * Sequences flush, fill and run, and opens the write side two cycles ahead of read
 */
`timescale 1ns/1ps

module read_startup_ctrl (
    input  logic                            pll_afi_clk,
    input  logic                            reset_n_afi_clk,
    input  logic                            fifo_reset,
    input  logic [rdp_pkg::TIMER_WIDTH-1:0] count,
    output logic                            timer_restart,
    output rdp_pkg::fifo_ctrl_t             fifo_ctrl,
    output rdp_pkg::startup_state_e         state
);
    import rdp_pkg::*;

    // The two-count gap between these sets the fixed FIFO fill level
    localparam int WR_START = 5;
    localparam int RD_START = 7;

    // The timer starts over on the edge that leaves the flush state
    assign timer_restart = (state == ST_FLUSH);

    always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
    begin
        if (!reset_n_afi_clk)
        begin
            state     <= ST_FILL;
            fifo_ctrl <= '0;
        end
        else if (fifo_reset)
        begin
            // A sequencer reset wins in every state
            state           <= ST_FLUSH;
            fifo_ctrl.flush <= 1'b1;
            fifo_ctrl.wr_en <= 1'b0;
            fifo_ctrl.rd_en <= 1'b0;
        end
        else
        begin
            case (state)
                ST_FLUSH:
                begin
                    // Flush lasts exactly one cycle
                    fifo_ctrl.flush <= 1'b0;
                    state           <= ST_FILL;
                end
                ST_FILL:
                begin
                    if (count > TIMER_WIDTH'(WR_START))
                        fifo_ctrl.wr_en <= 1'b1;
                    if (count > TIMER_WIDTH'(RD_START))
                    begin
                        fifo_ctrl.rd_en <= 1'b1;
                        state           <= ST_RUN;
                    end
                end
                ST_RUN:
                begin
                    // Both sides stream until the next FIFO reset
                    fifo_ctrl.wr_en <= 1'b1;
                    fifo_ctrl.rd_en <= 1'b1;
                end
                default:
                    state <= ST_FILL;
            endcase
        end
    end

    // Reading needs the write side open, and opened at least two cycles before
    rd_follows_wr: assert property (
        @(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
        fifo_ctrl.rd_en |-> fifo_ctrl.wr_en
    );

    rd_lead_two: assert property (
        @(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
        $rose(fifo_ctrl.rd_en) |-> $past(fifo_ctrl.wr_en, 2)
    );

endmodule

// ==== src/read_valid_predictor.sv ====
/*
 * Read-valid predictor
 * Delays the read enable through a shift register and taps it at a calibrated point
 */
`timescale 1ns/1ps

module read_valid_predictor #(
    parameter int MAX_READ_LATENCY = rdp_pkg::MAX_READ_LATENCY
) (
    input  logic                                pll_afi_clk,
    input  logic                                reset_n_afi_clk,
    input  logic [rdp_pkg::AFI_RATE_RATIO-1:0]  afi_rdata_en,
    input  logic                                incr_vfifo,
    output logic [rdp_pkg::AFI_RATE_RATIO-1:0]  afi_rdata_valid,
    output logic [rdp_pkg::VFIFO_PTR_WIDTH-1:0] vfifo_pointer
);
    import rdp_pkg::*;

    // Lowest tap sits this far down the chain, so pointer 0 still sees a full delay
    localparam int VFIFO_OFFSET = MAX_READ_LATENCY - 8;
    localparam int TAP_WIDTH    = $clog2(MAX_READ_LATENCY);

    logic [MAX_READ_LATENCY-1:0] vfifo;
    logic [TAP_WIDTH-1:0]        tap;
    logic                        valid_q;

    // The controller raises both enable bits together, so bit 0 stands for the pair
    always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
    begin
        if (!reset_n_afi_clk)
            vfifo <= '0;
        else
            vfifo <= {vfifo[MAX_READ_LATENCY-2:0], afi_rdata_en[0]};
    end

    // Calibration steps the pointer one cycle later at a time, wrapping after 7
    always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
    begin
        if (!reset_n_afi_clk)
            vfifo_pointer <= '0;
        else if (incr_vfifo)
            vfifo_pointer <= vfifo_pointer + 1'b1;
    end

    assign tap = TAP_WIDTH'(VFIFO_OFFSET) + TAP_WIDTH'(vfifo_pointer);

    // One more register stage after the tap gives 9 cycles at pointer 0
    always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
    begin
        if (!reset_n_afi_clk)
            valid_q <= 1'b0;
        else
            valid_q <= vfifo[tap];
    end

    assign afi_rdata_valid = {AFI_RATE_RATIO{valid_q}};

endmodule

// ==== src/rdata_resync_fifo.sv ====
/*
 * Eight-entry read-data resync FIFO with a registered output
 * Words leave reordered from group-major to beat-major slices
 */
`timescale 1ns/1ps

module rdata_resync_fifo #(
    parameter int  NUM_OF_DQDQS     = rdp_pkg::NUM_OF_DQDQS,
    parameter int  DQDQS_DATA_WIDTH = rdp_pkg::DQDQS_DATA_WIDTH,
    localparam int DATA_WIDTH       = rdp_pkg::BEATS_PER_WORD * NUM_OF_DQDQS * DQDQS_DATA_WIDTH
) (
    input  logic                  pll_afi_clk,
    input  logic                  reset_n_afi_clk,
    input  logic [DATA_WIDTH-1:0] rdata_hr,
    input  rdp_pkg::fifo_ctrl_t   fifo_ctrl,
    output logic [DATA_WIDTH-1:0] afi_rdata,
    output logic                  fifo_error
);
    import rdp_pkg::*;

    localparam int DEPTH     = 8;
    localparam int PTR_WIDTH = $clog2(DEPTH);

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [PTR_WIDTH-1:0]  wr_ptr;
    logic [PTR_WIDTH-1:0]  rd_ptr;
    logic [PTR_WIDTH:0]    fill_level;
    logic                  full;
    logic                  empty;
    logic                  do_wr;
    logic                  do_rd;
    logic [DATA_WIDTH-1:0] rd_word;
    logic [DATA_WIDTH-1:0] rd_word_reord;

    assign full  = (fill_level == (PTR_WIDTH+1)'(DEPTH));
    assign empty = (fill_level == '0);

    // A write into a full FIFO only goes ahead when a read frees a slot the same cycle
    assign do_wr = fifo_ctrl.wr_en && (!full || fifo_ctrl.rd_en);
    assign do_rd = fifo_ctrl.rd_en && !empty;

    always_ff @(posedge pll_afi_clk)
    begin
        if (do_wr)
            mem[wr_ptr] <= rdata_hr;
    end

    assign rd_word = mem[rd_ptr];

    // Input slice (group g, beat b) moves to output slice (beat b, group g)
    for (genvar g = 0; g < NUM_OF_DQDQS; g++)
    begin : g_group
        for (genvar b = 0; b < BEATS_PER_WORD; b++)
        begin : g_beat
            assign rd_word_reord[(b*NUM_OF_DQDQS+g)*DQDQS_DATA_WIDTH +: DQDQS_DATA_WIDTH] =
                rd_word[(g*BEATS_PER_WORD+b)*DQDQS_DATA_WIDTH +: DQDQS_DATA_WIDTH];
        end
    end

    always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
    begin
        if (!reset_n_afi_clk)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill_level <= '0;
            afi_rdata  <= '0;
            fifo_error <= 1'b0;
        end
        else if (fifo_ctrl.flush)
        begin
            // Flush drops all stored words and zeroes the output
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill_level <= '0;
            afi_rdata  <= '0;
            fifo_error <= 1'b0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
            begin
                rd_ptr    <= rd_ptr + 1'b1;
                afi_rdata <= rd_word_reord;
            end
            case ({do_wr, do_rd})
                2'b10:   fill_level <= fill_level + 1'b1;
                2'b01:   fill_level <= fill_level - 1'b1;
                default: fill_level <= fill_level;
            endcase
            // One-cycle flag for a request that had to be refused
            fifo_error <= (fifo_ctrl.wr_en && !do_wr) || (fifo_ctrl.rd_en && !do_rd);
        end
    end

    // The startup FSM keeps the fill level at two, so neither fault should happen
    no_overflow: assert property (
        @(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
        fifo_ctrl.wr_en |-> (!full || fifo_ctrl.rd_en)
    );

    no_underflow: assert property (
        @(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
        fifo_ctrl.rd_en |-> !empty
    );

endmodule

// ==== src/read_datapath.sv ====
/*
 * Read datapath top level in the AFI clock domain
 * Connects the register slave, startup FSM and timer, valid predictor and resync FIFO
 */
`timescale 1ns/1ps

module read_datapath #(
    parameter int  NUM_OF_DQDQS     = rdp_pkg::NUM_OF_DQDQS,
    parameter int  DQDQS_DATA_WIDTH = rdp_pkg::DQDQS_DATA_WIDTH,
    parameter int  MAX_READ_LATENCY = rdp_pkg::MAX_READ_LATENCY,
    localparam int AFI_DATA_WIDTH   = rdp_pkg::BEATS_PER_WORD * NUM_OF_DQDQS * DQDQS_DATA_WIDTH
) (
    input  logic                               pll_afi_clk,
    input  logic                               reset_n_afi_clk,
    input  logic [AFI_DATA_WIDTH-1:0]          rdata_hr,
    input  logic [rdp_pkg::AFI_RATE_RATIO-1:0] afi_rdata_en,
    input  logic                               wb_cyc,
    input  logic                               wb_stb,
    input  logic                               wb_we,
    input  logic                               wb_adr,
    input  logic [rdp_pkg::WB_DATA_WIDTH-1:0]  wb_dat_i,
    output logic [rdp_pkg::WB_DATA_WIDTH-1:0]  wb_dat_o,
    output logic                               wb_ack,
    output logic [AFI_DATA_WIDTH-1:0]          afi_rdata,
    output logic [rdp_pkg::AFI_RATE_RATIO-1:0] afi_rdata_valid
);
    import rdp_pkg::*;

    seq_cmd_t                   seq_cmd;
    fifo_ctrl_t                 fifo_ctrl;
    startup_state_e             state;
    logic [TIMER_WIDTH-1:0]     count;
    logic                       timer_restart;
    logic [VFIFO_PTR_WIDTH-1:0] vfifo_pointer;
    logic                       fifo_error;

    // Sequencer stand-in on the Wishbone bus
    seq_csr_wb i_seq_csr_wb (
        .pll_afi_clk     (pll_afi_clk),
        .reset_n_afi_clk (reset_n_afi_clk),
        .wb_cyc          (wb_cyc),
        .wb_stb          (wb_stb),
        .wb_we           (wb_we),
        .wb_adr          (wb_adr),
        .wb_dat_i        (wb_dat_i),
        .wb_dat_o        (wb_dat_o),
        .wb_ack          (wb_ack),
        .seq_cmd         (seq_cmd),
        .vfifo_pointer   (vfifo_pointer),
        .state           (state),
        .fifo_error      (fifo_error)
    );

    startup_timer i_startup_timer (
        .pll_afi_clk     (pll_afi_clk),
        .reset_n_afi_clk (reset_n_afi_clk),
        .restart         (timer_restart),
        .count           (count)
    );

    read_startup_ctrl i_read_startup_ctrl (
        .pll_afi_clk     (pll_afi_clk),
        .reset_n_afi_clk (reset_n_afi_clk),
        .fifo_reset      (seq_cmd.fifo_reset),
        .count           (count),
        .timer_restart   (timer_restart),
        .fifo_ctrl       (fifo_ctrl),
        .state           (state)
    );

    read_valid_predictor #(
        .MAX_READ_LATENCY (MAX_READ_LATENCY)
    ) i_read_valid_predictor (
        .pll_afi_clk     (pll_afi_clk),
        .reset_n_afi_clk (reset_n_afi_clk),
        .afi_rdata_en    (afi_rdata_en),
        .incr_vfifo      (seq_cmd.incr_vfifo),
        .afi_rdata_valid (afi_rdata_valid),
        .vfifo_pointer   (vfifo_pointer)
    );

    // Data path, two cycles from rdata_hr to afi_rdata once running
    rdata_resync_fifo #(
        .NUM_OF_DQDQS     (NUM_OF_DQDQS),
        .DQDQS_DATA_WIDTH (DQDQS_DATA_WIDTH)
    ) i_rdata_resync_fifo (
        .pll_afi_clk     (pll_afi_clk),
        .reset_n_afi_clk (reset_n_afi_clk),
        .rdata_hr        (rdata_hr),
        .fifo_ctrl       (fifo_ctrl),
        .afi_rdata       (afi_rdata),
        .fifo_error      (fifo_error)
    );

endmodule

// ==== bench/tb_clock_gen.sv ====
/*
 * Testbench clock source with a 4 ns period and an active-low reset
 * held for the first five rising edges
 */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int RESET_CYCLES = 5
) (
    output logic pll_afi_clk,
    output logic reset_n_afi_clk
);

    // Half of the 4 ns AFI clock period
    localparam realtime HALF_PERIOD = 2.0ns;

    initial
    begin
        pll_afi_clk = 1'b0;
        forever
            #(HALF_PERIOD) pll_afi_clk = ~pll_afi_clk;
    end

    // Release on a rising edge so the first active edge is a whole cycle later
    initial
    begin
        reset_n_afi_clk = 1'b0;
        repeat (RESET_CYCLES)
            @(posedge pll_afi_clk);
        reset_n_afi_clk <= 1'b1;
    end

endmodule

// ==== bench/read_datapath_tb.sv ====
/*
 * Table-driven testbench for the read datapath
 * Holds the Wishbone driver, the data and read-valid reference model and the check task
 */
`timescale 1ns/1ps

module read_datapath_tb;
    import rdp_pkg::*;

    localparam int NUM_TESTS     = 6;
    localparam int WB_TIMEOUT    = 8;
    localparam int VALID_TIMEOUT = 32;
    localparam int RUN_TIMEOUT   = 12;
    localparam int RESET_TIMEOUT = 20;
    localparam int STREAM_CYCLES = 12;

    // One Wishbone request as the master holds it until ack
    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic                     adr;
        logic [WB_DATA_WIDTH-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        int   incr;
        logic fifo_reset;
        int   delay;
    } test_row_t;

    // Columns are pointer increments, FIFO reset first, expected valid delay in cycles
    localparam test_row_t TEST_TABLE [NUM_TESTS] = '{
        '{0, 1'b0, 9},
        '{3, 1'b0, 12},
        '{4, 1'b1, 16},
        '{1, 1'b0, 9},
        '{8, 1'b0, 9},
        '{2, 1'b1, 11}
    };

    logic                      pll_afi_clk;
    logic                      reset_n_afi_clk;
    logic [AFI_DATA_WIDTH-1:0] rdata_hr;
    logic [AFI_RATE_RATIO-1:0] afi_rdata_en;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    logic                      wb_adr;
    logic [WB_DATA_WIDTH-1:0]  wb_dat_i;
    logic [WB_DATA_WIDTH-1:0]  wb_dat_o;
    logic                      wb_ack;
    logic [AFI_DATA_WIDTH-1:0] afi_rdata;
    logic [AFI_RATE_RATIO-1:0] afi_rdata_valid;

    // Values to be driven on the next rising edge
    wb_req_t                   wb_next;
    logic [AFI_RATE_RATIO-1:0] en_next;
    // Words the DUT sampled on the last three edges, newest first
    logic [AFI_DATA_WIDTH-1:0] sampled [3];
    int                        cycle;
    int                        en_cycle;
    int                        valid_cycle;
    logic                      valid_seen;
    logic [AFI_RATE_RATIO-1:0] valid_bits;
    logic                      align_on;
    logic                      timed_out;
    int                        exp_ptr;
    int                        checks;
    int                        errors;
    int                        tests_run;

    tb_clock_gen i_tb_clock_gen (
        .pll_afi_clk     (pll_afi_clk),
        .reset_n_afi_clk (reset_n_afi_clk)
    );

    read_datapath #(
        .NUM_OF_DQDQS     (NUM_OF_DQDQS),
        .DQDQS_DATA_WIDTH (DQDQS_DATA_WIDTH),
        .MAX_READ_LATENCY (MAX_READ_LATENCY)
    ) i_read_datapath (
        .pll_afi_clk     (pll_afi_clk),
        .reset_n_afi_clk (reset_n_afi_clk),
        .rdata_hr        (rdata_hr),
        .afi_rdata_en    (afi_rdata_en),
        .wb_cyc          (wb_cyc),
        .wb_stb          (wb_stb),
        .wb_we           (wb_we),
        .wb_adr          (wb_adr),
        .wb_dat_i        (wb_dat_i),
        .wb_dat_o        (wb_dat_o),
        .wb_ack          (wb_ack),
        .afi_rdata       (afi_rdata),
        .afi_rdata_valid (afi_rdata_valid)
    );

    // Group-major slice (g*4+b) moves to beat-major slice (b*groups+g)
    function automatic logic [AFI_DATA_WIDTH-1:0] reorder_beats(
        input logic [AFI_DATA_WIDTH-1:0] word
    );
        logic [AFI_DATA_WIDTH-1:0] result;
        result = '0;
        for (int g = 0; g < NUM_OF_DQDQS; g++)
            for (int b = 0; b < 4; b++)
                result[(b*NUM_OF_DQDQS+g)*DQDQS_DATA_WIDTH +: DQDQS_DATA_WIDTH] =
                    word[(g*4+b)*DQDQS_DATA_WIDTH +: DQDQS_DATA_WIDTH];
        return result;
    endfunction

    task automatic check_value(input string what, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("MISMATCH at time %0t: %s is %0h, expected %0h", $time, what, actual,
                     expected);
        end
    endtask

    // One clock cycle: inputs change on the rising edge, outputs are read on the falling one
    task automatic tick();
        @(posedge pll_afi_clk);
        cycle++;
        // The values still on the inputs are the ones the DUT takes on this edge
        sampled[2] = sampled[1];
        sampled[1] = sampled[0];
        sampled[0] = rdata_hr;
        if (afi_rdata_en[0])
            en_cycle = cycle;
        rdata_hr     <= {$urandom, $urandom};
        afi_rdata_en <= en_next;
        en_next       = '0;
        wb_cyc       <= wb_next.cyc;
        wb_stb       <= wb_next.stb;
        wb_we        <= wb_next.we;
        wb_adr       <= wb_next.adr;
        wb_dat_i     <= wb_next.dat;
        @(negedge pll_afi_clk);
        // A word taken on edge k shows up reordered after edge k+2
        if (align_on)
            check_value("afi_rdata", afi_rdata, reorder_beats(sampled[2]));
        if (afi_rdata_valid != '0 && !valid_seen)
        begin
            valid_seen  = 1'b1;
            valid_cycle = cycle;
            valid_bits  = afi_rdata_valid;
        end
    endtask

    // Holds the request until ack, then drops it on the following edge
    task automatic wb_access(input logic we, input csr_reg_e adr,
                             input logic [WB_DATA_WIDTH-1:0] wdata,
                             output logic [WB_DATA_WIDTH-1:0] rdata);
        int waited;
        waited      = 0;
        rdata       = '0;
        wb_next.cyc = 1'b1;
        wb_next.stb = 1'b1;
        wb_next.we  = we;
        wb_next.adr = adr;
        wb_next.dat = wdata;
        tick();
        while (!wb_ack && waited < WB_TIMEOUT)
        begin
            tick();
            waited++;
        end
        if (wb_ack)
            rdata = wb_dat_o;
        else
        begin
            $display("Wishbone access got no ack within %0d cycles", WB_TIMEOUT);
            timed_out = 1'b1;
        end
        wb_next = '0;
        tick();
    endtask

    task automatic wb_write(input csr_reg_e adr, input logic [WB_DATA_WIDTH-1:0] wdata);
        logic [WB_DATA_WIDTH-1:0] unused;
        wb_access(1'b1, adr, wdata, unused);
    endtask

    task automatic read_status(output status_t st);
        logic [WB_DATA_WIDTH-1:0] rdata;
        wb_access(1'b0, REG_STATUS, '0, rdata);
        st = status_t'(rdata);
    endtask

    // Polls the status register until the startup FSM reports the run state
    task automatic wait_for_run();
        status_t st;
        int      polls;
        polls = 0;
        st    = '0;
        while (st.state != ST_RUN && polls < RUN_TIMEOUT && !timed_out)
        begin
            read_status(st);
            polls++;
        end
        if (st.state != ST_RUN && !timed_out)
        begin
            $display("Startup FSM did not reach the run state after %0d status reads", polls);
            timed_out = 1'b1;
        end
    endtask

    // FIFO reset through REG_CTRL bit 0, then wait for the output to clear and refill
    task automatic flush_and_restart();
        int waited;
        waited   = 0;
        align_on = 1'b0;
        wb_write(REG_CTRL, 32'h1);
        if (timed_out)
            return;
        while (afi_rdata != '0 && waited < WB_TIMEOUT)
        begin
            tick();
            waited++;
        end
        if (afi_rdata != '0)
        begin
            $display("afi_rdata was not cleared within %0d cycles of the FIFO reset",
                     WB_TIMEOUT);
            timed_out = 1'b1;
            return;
        end
        // The pulse leaves with ack, the FSM flushes one edge later and the FIFO clears
        // on the edge after that, which is one edge past the end of the write
        check_value("cycles to flush clear", 64'(waited), 64'(1));
        wait_for_run();
        align_on = !timed_out;
    endtask

    // Single enable pulse, then the cycles until afi_rdata_valid rises
    task automatic measure_valid(input int exp_delay);
        int waited;
        waited     = 0;
        valid_seen = 1'b0;
        en_next    = '1;
        tick();
        while (!valid_seen && waited < VALID_TIMEOUT)
        begin
            tick();
            waited++;
        end
        if (!valid_seen)
        begin
            $display("afi_rdata_valid did not rise within %0d cycles of the enable",
                     VALID_TIMEOUT);
            timed_out = 1'b1;
            return;
        end
        check_value("valid delay", 64'(valid_cycle - en_cycle), 64'(exp_delay));
        check_value("valid bits", 64'(valid_bits), 64'({AFI_RATE_RATIO{1'b1}}));
        tick();
        check_value("valid after pulse", 64'(afi_rdata_valid), 64'(0));
    endtask

    task automatic check_status(input string tag);
        status_t st;
        read_status(st);
        if (timed_out)
            return;
        check_value({tag, " pointer"}, 64'(st.vfifo_pointer), 64'(exp_ptr));
        check_value({tag, " state"}, 64'(st.state), 64'(ST_RUN));
        check_value({tag, " fifo error"}, 64'(st.fifo_error), 64'(0));
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        $display("%s %s", name,
                 (errors == errors_before && !timed_out) ? "ok" : "failed");
    endtask

    task automatic run_test(input int idx);
        test_row_t row;
        int        errors_before;
        row           = TEST_TABLE[idx];
        errors_before = errors;
        if (row.fifo_reset)
            flush_and_restart();
        for (int n = 0; n < row.incr && !timed_out; n++)
            wb_write(REG_CTRL, 32'h2);
        // The pointer is three bits wide and wraps after 7
        exp_ptr = (exp_ptr + row.incr) % 8;
        if (!timed_out)
            check_status($sformatf("test %0d", idx));
        repeat (STREAM_CYCLES)
            tick();
        if (!timed_out)
            measure_valid(row.delay);
        report_test($sformatf("test %0d", idx), errors_before);
    endtask

    initial
    begin
        int waited;
        waited = 0;
        void'($urandom(28));
        rdata_hr        = '0;
        afi_rdata_en    = '0;
        wb_cyc          = 1'b0;
        wb_stb          = 1'b0;
        wb_we           = 1'b0;
        wb_adr          = 1'b0;
        wb_dat_i        = '0;
        wb_next         = '0;
        en_next         = '0;
        sampled         = '{default: '0};
        cycle           = 0;
        en_cycle        = 0;
        valid_cycle     = 0;
        valid_seen      = 1'b0;
        valid_bits      = '0;
        align_on        = 1'b0;
        timed_out       = 1'b0;
        exp_ptr         = 0;
        checks          = 0;
        errors          = 0;
        tests_run       = 0;
        while (!reset_n_afi_clk && waited < RESET_TIMEOUT)
        begin
            tick();
            waited++;
        end
        if (!reset_n_afi_clk)
        begin
            $display("Reset was never released");
            timed_out = 1'b1;
        end
        else
        begin
            // Outputs must be quiet straight after reset
            check_value("afi_rdata_valid after reset", 64'(afi_rdata_valid), 64'(0));
            check_value("wb_ack after reset", 64'(wb_ack), 64'(0));
            check_value("afi_rdata after reset", afi_rdata, '0);
            wait_for_run();
            check_status("startup");
            align_on = !timed_out;
            repeat (STREAM_CYCLES)
                tick();
            report_test("startup", 0);
        end
        for (int i = 0; i < NUM_TESTS && !timed_out; i++)
            run_test(i);
        $display("%0d tests, %0d checks, %0d errors%s", tests_run, checks, errors,
                 timed_out ? ", stopped on a timeout" : "");
        if (errors == 0 && !timed_out)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// ==== sim.f ====
src/rdp_pkg.sv
src/seq_csr_wb.sv
src/startup_timer.sv
src/read_startup_ctrl.sv
src/read_valid_predictor.sv
src/rdata_resync_fifo.sv
src/read_datapath.sv
bench/tb_clock_gen.sv
bench/read_datapath_tb.sv

// ==== Makefile ====
# Verilator build and run for the read datapath testbench

SRCS := $(shell cat sim.f)
SIM  := obj_dir/Vread_datapath_tb

.PHONY: all run clean

all: run

# The binary is rebuilt only when a source or the file list changes
$(SIM): sim.f $(SRCS)
	verilator --binary --timing --assert -f sim.f --top-module read_datapath_tb \
		-Mdir obj_dir -o Vread_datapath_tb

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q "TB FAILED" sim.log || ! grep -q "TB PASSED" sim.log; then \
		echo "Simulation failed, see sim.log"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
